// ==== common/egr_pkg.sv ====
// Egress stage shared types
// Wide beat, port number and statistics counter definitions

`include "egr_settings.svh"

package egr_pkg;

    ////////////////////
    // Scalar types

    // Port number carried with each beat
    typedef logic [$clog2(`EGR_NUM_PORTS)-1:0] egr_port_id_t;

    // One statistics counter
    typedef logic [`EGR_CNT_WIDTH-1:0] egr_cnt_t;

    ////////////////////
    // Structs

    // One wide beat of the input stream
    // keep is contiguous from byte 0, byte 0 sits in the low data bits
    typedef struct packed {
        logic [`EGR_BUS_BYTES*8-1:0] data;
        logic [`EGR_BUS_BYTES-1:0]   keep;
        logic                        last;
        egr_port_id_t                port;
    } egr_beat_t;

    // Per-port statistics
    typedef struct packed {
        egr_cnt_t pkts_in;
        egr_cnt_t pkts_out;
        egr_cnt_t drop_full;
        egr_cnt_t drop_disabled;
    } egr_cnt_set_t;

endpackage

// ==== common/egr_settings.svh ====
// Egress stage build settings
// Bus and port widths, port counts, buffer sizing and counter width

`ifndef EGR_SETTINGS_SVH
`define EGR_SETTINGS_SVH

// Input stream beat width in bytes
`define EGR_BUS_BYTES 16

// Egress port layout, narrow ports take the low port numbers
`define EGR_NUM_PORTS 4
`define EGR_NUM_NARROW 2
`define EGR_NARROW_BYTES 4
`define EGR_WIDE_BYTES 8

// Per-port packet buffer, counted in wide beats
`define EGR_BUF_DEPTH 32

// Largest packet in wide beats, also the free space needed for admission
`define EGR_MAX_PKT_BEATS 8

// Statistics counter width
`define EGR_CNT_WIDTH 32

`endif

// ==== dv/egr_subsystem_tb.sv ====
// Egress subsystem testbench
// Random packets against a reference model of routing, width split, drops and counters

`include "egr_settings.svh"

module egr_subsystem_tb
    import egr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_WIDE   = `EGR_NUM_PORTS - `EGR_NUM_NARROW;
    localparam int N_ROUTE    = 40;
    localparam int N_BACKP    = 60;
    localparam int N_DISABLED = 8;
    localparam int N_FULL     = `EGR_BUF_DEPTH / `EGR_MAX_PKT_BEATS + 2;
    localparam int TOTAL_PKTS = N_ROUTE + N_BACKP + N_DISABLED + N_FULL;
    localparam int TIMEOUT_CYCLES =
        4 * TOTAL_PKTS * `EGR_MAX_PKT_BEATS * (`EGR_BUS_BYTES / `EGR_NARROW_BYTES) + 2000;
    // Outstanding pieces per port above which new packets wait
    localparam int GATE = `EGR_BUF_DEPTH - 2 * `EGR_MAX_PKT_BEATS;

    // One expected output piece sized for the widest port
    typedef struct packed {
        logic [`EGR_WIDE_BYTES*8-1:0] data;
        logic [`EGR_WIDE_BYTES-1:0]   keep;
        logic                         last;
    } piece_t;

    logic                             egr_bus;
    logic                             rst_n;
    logic                             in_valid;
    egr_beat_t                        in_beat;
    logic [`EGR_NUM_PORTS-1:0]        egr_ports_enable;
    logic [`EGR_NUM_PORTS-1:0]        egr_cnts_clear;
    logic [`EGR_NUM_NARROW-1:0]       narrow_valid;
    logic [`EGR_NARROW_BYTES*8-1:0]   narrow_data [`EGR_NUM_NARROW];
    logic [`EGR_NARROW_BYTES-1:0]     narrow_keep [`EGR_NUM_NARROW];
    logic [`EGR_NUM_NARROW-1:0]       narrow_last;
    logic [`EGR_NUM_NARROW-1:0]       narrow_ready;
    logic [NUM_WIDE-1:0]              wide_valid;
    logic [`EGR_WIDE_BYTES*8-1:0]     wide_data [NUM_WIDE];
    logic [`EGR_WIDE_BYTES-1:0]       wide_keep [NUM_WIDE];
    logic [NUM_WIDE-1:0]              wide_last;
    logic [NUM_WIDE-1:0]              wide_ready;
    egr_cnt_set_t                     egr_cnts [`EGR_NUM_PORTS];
    logic [`EGR_NUM_PORTS-1:0]        egr_buf_full_drop;

    integer seed;
    int     errors;
    int     nchecks;
    int     test_err_start;
    int     cycles;
    bit     bp_on;
    bit     hold [`EGR_NUM_PORTS];
    int     fill [`EGR_NUM_PORTS];
    // Model tallies per port
    int     acc [`EGR_NUM_PORTS];
    int     dfull [`EGR_NUM_PORTS];
    int     ddis [`EGR_NUM_PORTS];
    int     sent [`EGR_NUM_PORTS];
    int     full_pulses [`EGR_NUM_PORTS];
    piece_t exp_q [`EGR_NUM_PORTS][$];

    egr_subsystem dut (.*);

    always #50ns egr_bus = ~egr_bus;

    ////////////////////
    // Reference model

    // Slices of one wide beat as the port should emit them
    function automatic void expected_pieces(egr_beat_t b, int p);
        int     pb;
        int     n;
        int     k;
        bit     done;
        bit     nxt_any;
        piece_t pc;
        pb   = (p < `EGR_NUM_NARROW) ? `EGR_NARROW_BYTES : `EGR_WIDE_BYTES;
        n    = `EGR_BUS_BYTES / pb;
        k    = 0;
        done = 1'b0;
        while (!done) begin
            pc = '0;
            for (int j = 0; j < pb; j++) begin
                pc.data[j*8 +: 8] = b.data[(k*pb + j)*8 +: 8];
                pc.keep[j]        = b.keep[k*pb + j];
            end
            nxt_any = 1'b0;
            if (k < n - 1) begin
                for (int j = 0; j < pb; j++) begin
                    nxt_any = nxt_any | b.keep[(k+1)*pb + j];
                end
            end
            done    = !nxt_any;
            pc.last = b.last && done;
            exp_q[p].push_back(pc);
            k++;
        end
    endfunction

    // Admission decision taken when the packet starts
    function automatic bit model_admit(int p, int nbeats);
        if (!egr_ports_enable[p]) begin
            ddis[p]++;
            return 1'b0;
        end
        if (hold[p] && (fill[p] + `EGR_MAX_PKT_BEATS > `EGR_BUF_DEPTH)) begin
            dfull[p]++;
            return 1'b0;
        end
        if (hold[p]) begin
            fill[p] += nbeats;
        end
        acc[p]++;
        return 1'b1;
    endfunction

    ////////////////////
    // Checks and monitors

    task automatic check_value(string name, logic [63:0] exp, logic [63:0] got);
        nchecks++;
        if (exp !== got) begin
            $display("Mismatch %s expected %0h got %0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_output(int p, logic v, logic r, logic [63:0] d, logic [7:0] k,
                                logic l);
        piece_t e;
        if (v && r) begin
            if (exp_q[p].size() == 0) begin
                $display("Port %0d delivered a piece while no packet was expected", p);
                errors++;
            end else begin
                e = exp_q[p].pop_front();
                check_value($sformatf("port%0d data", p), e.data, d);
                check_value($sformatf("port%0d keep", p), e.keep, k);
                check_value($sformatf("port%0d last", p), e.last, l);
            end
            if (l) begin
                sent[p]++;
            end
        end
    endtask

    always @(posedge egr_bus) begin
        if (rst_n) begin
            for (int i = 0; i < `EGR_NUM_NARROW; i++) begin
                check_output(i, narrow_valid[i], narrow_ready[i], 64'(narrow_data[i]),
                             8'(narrow_keep[i]), narrow_last[i]);
            end
            for (int j = 0; j < NUM_WIDE; j++) begin
                check_output(`EGR_NUM_NARROW + j, wide_valid[j], wide_ready[j],
                             64'(wide_data[j]), 8'(wide_keep[j]), wide_last[j]);
            end
            for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
                if (egr_buf_full_drop[p]) begin
                    full_pulses[p]++;
                end
            end
        end
    end

    task automatic check_counters(int p);
        check_value($sformatf("port%0d pkts_in", p), acc[p], egr_cnts[p].pkts_in);
        check_value($sformatf("port%0d pkts_out", p), acc[p], egr_cnts[p].pkts_out);
        check_value($sformatf("port%0d drop_full", p), dfull[p], egr_cnts[p].drop_full);
        check_value($sformatf("port%0d drop_disabled", p), ddis[p],
                    egr_cnts[p].drop_disabled);
    endtask

    ////////////////////
    // Stimulus

    // One clock with the sink ready lines updated after the edge
    task automatic tick();
        logic r;
        @(posedge egr_bus);
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            r = 1'b1;
            if (hold[p]) begin
                r = 1'b0;
            end else if (bp_on) begin
                r = $random(seed) & 1;
            end
            if (p < `EGR_NUM_NARROW) begin
                narrow_ready[p] <= r;
            end else begin
                wide_ready[p - `EGR_NUM_NARROW] <= r;
            end
        end
    endtask

    task automatic send_packet(int p, int nbeats, bit full_keep);
        egr_beat_t b;
        bit        adm;
        int        nb;
        adm = model_admit(p, nbeats);
        for (int i = 0; i < nbeats; i++) begin
            for (int w = 0; w < `EGR_BUS_BYTES / 4; w++) begin
                b.data[w*32 +: 32] = $random(seed);
            end
            b.last = (i == nbeats - 1);
            b.port = egr_port_id_t'(p);
            b.keep = '1;
            if (b.last && !full_keep) begin
                nb     = 1 + $unsigned($random(seed)) % `EGR_BUS_BYTES;
                b.keep = {`EGR_BUS_BYTES{1'b1}} >> (`EGR_BUS_BYTES - nb);
            end
            if (adm) begin
                expected_pieces(b, p);
            end
            tick();
            in_valid <= 1'b1;
            in_beat  <= b;
        end
        tick();
        in_valid <= 1'b0;
    endtask

    task automatic random_packets(int npkts);
        int p;
        int n;
        for (int i = 0; i < npkts; i++) begin
            p = $unsigned($random(seed)) % `EGR_NUM_PORTS;
            n = 1 + $unsigned($random(seed)) % `EGR_MAX_PKT_BEATS;
            while (exp_q[p].size() > GATE) begin
                tick();
            end
            send_packet(p, n, 1'b0);
        end
    endtask

    task automatic wait_drain();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            tick();
            busy = 1'b0;
            for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
                busy = busy | (exp_q[p].size() != 0);
            end
        end
        repeat (20) tick();
    endtask

    task automatic end_test(string name);
        $display("test %s done with %0d errors", name, errors - test_err_start);
        test_err_start = errors;
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge egr_bus);
            cycles++;
        end
        $display("timeout: outputs did not drain");
        $display("sim failed");
        $finish;
    end

    initial begin
        seed             = 32'h9e205507;
        egr_bus          = 1'b0;
        rst_n            = 1'b0;
        in_valid         = 1'b0;
        in_beat          = '0;
        egr_ports_enable = '1;
        egr_cnts_clear   = '0;
        narrow_ready     = '1;
        wide_ready       = '1;
        repeat (10) tick();
        rst_n <= 1'b1;
        repeat (5) tick();

        // Routing and width split with sinks always ready
        random_packets(N_ROUTE);
        wait_drain();
        end_test("routing");

        // Random sink back-pressure
        bp_on = 1'b1;
        random_packets(N_BACKP);
        wait_drain();
        bp_on = 1'b0;
        end_test("backpressure");

        // Port 3 disabled
        egr_ports_enable[3] <= 1'b0;
        tick();
        for (int i = 0; i < N_DISABLED; i++) begin
            send_packet(3, 1 + $unsigned($random(seed)) % `EGR_MAX_PKT_BEATS, 1'b0);
        end
        wait_drain();
        check_value("port3 drop_disabled", ddis[3], egr_cnts[3].drop_disabled);
        egr_ports_enable[3] <= 1'b1;
        tick();
        end_test("disabled");

        // Port 0 stalled until its buffer overflows
        hold[0] = 1'b1;
        fill[0] = 0;
        repeat (2) tick();
        for (int i = 0; i < N_FULL; i++) begin
            send_packet(0, `EGR_MAX_PKT_BEATS, 1'b1);
        end
        repeat (5) tick();
        check_value("port0 buf_full_drop pulses", dfull[0], full_pulses[0]);
        hold[0] = 1'b0;
        wait_drain();
        end_test("buffer_full");

        // Counter totals followed by a clear of port 1 only
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            check_counters(p);
            check_value($sformatf("port%0d sent", p), acc[p], sent[p]);
            check_value($sformatf("port%0d buf_full_drop pulses", p), dfull[p],
                        full_pulses[p]);
        end
        egr_cnts_clear <= 4'b0010;
        tick();
        egr_cnts_clear <= '0;
        repeat (3) tick();
        acc[1]   = 0;
        dfull[1] = 0;
        ddis[1]  = 0;
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
            check_counters(p);
        end
        end_test("counters");

        $display("%0d checks, %0d errors", nchecks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== egr_port/egr_port.sv ====
// Egress port
// Packet buffer, width adapter and statistics for one physical port

module egr_port
    import egr_pkg::*;
#(
    parameter int PORT_BYTES = 4
) (
    input  logic                    egr_bus,
    input  logic                    rst_n,
    input  logic                    enable,
    input  logic                    cnts_clear,
    input  logic                    wr_valid,
    input  egr_beat_t               wr_beat,
    output logic                    out_valid,
    output logic [PORT_BYTES*8-1:0] out_data,
    output logic [PORT_BYTES-1:0]   out_keep,
    output logic                    out_last,
    input  logic                    out_ready,
    output egr_cnt_set_t            cnts,
    output logic                    buf_full_drop
);

    logic      buf_valid;
    egr_beat_t buf_beat;
    logic      buf_ready;
    logic      pkt_accepted;
    logic      pkt_drop_full;
    logic      pkt_drop_disabled;
    logic      pkt_sent;

    egr_port_buffer u_buffer (
        .egr_bus           (egr_bus),
        .rst_n             (rst_n),
        .enable            (enable),
        .wr_valid          (wr_valid),
        .wr_beat           (wr_beat),
        .buf_valid         (buf_valid),
        .buf_beat          (buf_beat),
        .buf_ready         (buf_ready),
        .pkt_accepted      (pkt_accepted),
        .pkt_drop_full     (pkt_drop_full),
        .pkt_drop_disabled (pkt_drop_disabled)
    );

    egr_width_adapt #(
        .PORT_BYTES (PORT_BYTES)
    ) u_adapt (
        .egr_bus   (egr_bus),
        .rst_n     (rst_n),
        .buf_valid (buf_valid),
        .buf_beat  (buf_beat),
        .buf_ready (buf_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    // A packet counts as sent when its last piece transfers
    assign pkt_sent      = out_valid && out_ready && out_last;
    assign buf_full_drop = pkt_drop_full;

    egr_port_counters u_counters (
        .egr_bus           (egr_bus),
        .rst_n             (rst_n),
        .clear             (cnts_clear),
        .pkt_accepted      (pkt_accepted),
        .pkt_drop_full     (pkt_drop_full),
        .pkt_drop_disabled (pkt_drop_disabled),
        .pkt_sent          (pkt_sent),
        .cnts              (cnts)
    );

endmodule

// ==== egr_port/egr_port_buffer.sv ====
// Egress packet buffer
// Circular beat FIFO that admits or drops whole packets on their first beat

`include "egr_settings.svh"

module egr_port_buffer
    import egr_pkg::*;
(
    input  logic      egr_bus,
    input  logic      rst_n,
    input  logic      enable,
    input  logic      wr_valid,
    input  egr_beat_t wr_beat,
    output logic      buf_valid,
    output egr_beat_t buf_beat,
    input  logic      buf_ready,
    output logic      pkt_accepted,
    output logic      pkt_drop_full,
    output logic      pkt_drop_disabled
);

    localparam int AW = $clog2(`EGR_BUF_DEPTH);
    localparam int CW = $clog2(`EGR_BUF_DEPTH + 1);

    egr_beat_t     mem [`EGR_BUF_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          in_pkt;
    logic          keep_pkt;
    logic          first_beat;
    logic          room;
    logic          admit;
    logic          wr_en;
    logic          rd_en;

    ////////////////////
    // Admission

    assign first_beat = wr_valid && !in_pkt;
    // Space for a full-size packet must be free before it starts
    assign room  = (`EGR_BUF_DEPTH - int'(count)) >= `EGR_MAX_PKT_BEATS;
    assign admit = enable && room;

    // Later beats follow the decision made on the first one
    assign wr_en = wr_valid && (in_pkt ? keep_pkt : admit);
    assign rd_en = buf_valid && buf_ready;

    assign pkt_accepted      = first_beat && admit;
    assign pkt_drop_disabled = first_beat && !enable;
    assign pkt_drop_full     = first_beat && enable && !room;

    always_ff @(posedge egr_bus) begin
        if (!rst_n) begin
            in_pkt   <= 1'b0;
            keep_pkt <= 1'b0;
        end else if (wr_valid) begin
            in_pkt <= !wr_beat.last;
            if (!in_pkt) begin
                keep_pkt <= admit;
            end
        end
    end

    ////////////////////
    // Storage

    always_ff @(posedge egr_bus) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge egr_bus) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(`EGR_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(`EGR_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign buf_valid = (count != '0);
    assign buf_beat  = mem[rd_ptr];

    ////////////////////
    // Checks

    // Admission on the first beat must leave room for the whole packet
    a_no_overflow: assert property (
        @(posedge egr_bus) disable iff (!rst_n)
        wr_en |-> (count < CW'(`EGR_BUF_DEPTH))
    ) else $error("egr_port_buffer: write while full");

    // Adapter pops only while it holds a buffered beat
    a_no_underflow: assert property (
        @(posedge egr_bus) disable iff (!rst_n)
        buf_ready |-> (count != '0)
    ) else $error("egr_port_buffer: read while empty");

endmodule

// ==== egr_port/egr_port_counters.sv ====
// Egress port statistics
// Saturating packet and drop counters with a synchronous clear

module egr_port_counters
    import egr_pkg::*;
(
    input  logic         egr_bus,
    input  logic         rst_n,
    input  logic         clear,
    input  logic         pkt_accepted,
    input  logic         pkt_drop_full,
    input  logic         pkt_drop_disabled,
    input  logic         pkt_sent,
    output egr_cnt_set_t cnts
);

    // Increment that sticks at all ones
    function automatic egr_cnt_t bump(egr_cnt_t cur, logic ev);
        egr_cnt_t nxt;
        nxt = cur;
        if (ev && (cur != '1)) begin
            nxt = cur + 1'b1;
        end
        return nxt;
    endfunction

    // Clear takes priority over any event in the same cycle
    always_ff @(posedge egr_bus) begin
        if (!rst_n) begin
            cnts <= '0;
        end else if (clear) begin
            cnts <= '0;
        end else begin
            cnts.pkts_in       <= bump(cnts.pkts_in, pkt_accepted);
            cnts.pkts_out      <= bump(cnts.pkts_out, pkt_sent);
            cnts.drop_full     <= bump(cnts.drop_full, pkt_drop_full);
            cnts.drop_disabled <= bump(cnts.drop_disabled, pkt_drop_disabled);
        end
    end

endmodule

// ==== egr_port/egr_width_adapt.sv ====
// Egress width adapter
// Cuts each wide beat into port-width pieces with keep and last

`include "egr_settings.svh"

module egr_width_adapt
    import egr_pkg::*;
#(
    parameter int PORT_BYTES = 4
) (
    input  logic                    egr_bus,
    input  logic                    rst_n,
    input  logic                    buf_valid,
    input  egr_beat_t               buf_beat,
    output logic                    buf_ready,
    output logic                    out_valid,
    output logic [PORT_BYTES*8-1:0] out_data,
    output logic [PORT_BYTES-1:0]   out_keep,
    output logic                    out_last,
    input  logic                    out_ready
);

    localparam int NUM_PIECES = `EGR_BUS_BYTES / PORT_BYTES;
    localparam int IDX_W      = (NUM_PIECES > 1) ? $clog2(NUM_PIECES) : 1;

    logic [NUM_PIECES-1:0][PORT_BYTES*8-1:0] data_sl;
    logic [NUM_PIECES-1:0][PORT_BYTES-1:0]   keep_sl;
    logic [IDX_W-1:0]                        idx;
    logic                                    load;
    logic                                    final_piece;

    // Piece 0 is the low slice of the wide beat
    assign data_sl = buf_beat.data;
    assign keep_sl = buf_beat.keep;

    // Output register takes a piece when empty or being drained
    assign load = buf_valid && (!out_valid || out_ready);

    // Wide beat is released together with its final piece
    assign buf_ready = load && final_piece;

    // Final piece is the last one with any keep bit set
    always_comb begin
        final_piece = 1'b1;
        if (int'(idx) < NUM_PIECES - 1) begin
            final_piece = (keep_sl[idx + 1'b1] == '0);
        end
    end

    ////////////////////
    // Output register

    always_ff @(posedge egr_bus) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            idx       <= '0;
        end else if (load) begin
            out_valid <= 1'b1;
            idx       <= final_piece ? '0 : idx + 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge egr_bus) begin
        if (load) begin
            out_data <= data_sl[idx];
            out_keep <= keep_sl[idx];
            out_last <= buf_beat.last && final_piece;
        end
    end

    ////////////////////
    // Checks

    a_hold_stable: assert property (
        @(posedge egr_bus) disable iff (!rst_n)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_data) && $stable(out_keep) && $stable(out_last))
    ) else $error("egr_width_adapt: output changed under back-pressure");

endmodule

// ==== egr_subsystem.f ====
+incdir+common
common/egr_pkg.sv
rtl/egr_port_demux.sv
egr_port/egr_port_buffer.sv
egr_port/egr_width_adapt.sv
egr_port/egr_port_counters.sv
egr_port/egr_port.sv
rtl/egr_subsystem.sv
dv/egr_subsystem_tb.sv

// ==== rtl/egr_port_demux.sv ====
// Egress demultiplexer
// Registers each input beat and steers its valid to a single egress port

`include "egr_settings.svh"

module egr_port_demux
    import egr_pkg::*;
(
    input  logic                      egr_bus,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  egr_beat_t                 in_beat,
    output logic [`EGR_NUM_PORTS-1:0] port_beat_valid,
    output egr_beat_t                 port_beat
);

    // One-hot decode of the port field
    // Port numbers beyond the last port match nothing and are lost
    always_ff @(posedge egr_bus) begin
        if (!rst_n) begin
            port_beat_valid <= '0;
        end else begin
            for (int i = 0; i < `EGR_NUM_PORTS; i++) begin
                port_beat_valid[i] <= in_valid && (int'(in_beat.port) == i);
            end
        end
    end

    // Single registered copy of the beat seen by every port
    always_ff @(posedge egr_bus) begin
        if (in_valid) begin
            port_beat <= in_beat;
        end
    end

    ////////////////////
    // Checks

    a_valid_onehot: assert property (
        @(posedge egr_bus) disable iff (!rst_n)
        $onehot0(port_beat_valid)
    ) else $error("egr_port_demux: more than one port valid");

endmodule

// ==== rtl/egr_subsystem.sv ====
// Egress subsystem top level
// Demultiplexes the wide input stream onto narrow and wide egress ports

`include "egr_settings.svh"

module egr_subsystem
    import egr_pkg::*;
(
    input  logic                               egr_bus,
    input  logic                               rst_n,
    input  logic                               in_valid,
    input  egr_beat_t                          in_beat,
    input  logic [`EGR_NUM_PORTS-1:0]          egr_ports_enable,
    input  logic [`EGR_NUM_PORTS-1:0]          egr_cnts_clear,
    // Narrow ports, numbered from 0
    output logic [`EGR_NUM_NARROW-1:0]         narrow_valid,
    output logic [`EGR_NARROW_BYTES*8-1:0]     narrow_data [`EGR_NUM_NARROW],
    output logic [`EGR_NARROW_BYTES-1:0]       narrow_keep [`EGR_NUM_NARROW],
    output logic [`EGR_NUM_NARROW-1:0]         narrow_last,
    input  logic [`EGR_NUM_NARROW-1:0]         narrow_ready,
    // Wide ports, numbered after the narrow ones
    output logic [`EGR_NUM_PORTS-`EGR_NUM_NARROW-1:0] wide_valid,
    output logic [`EGR_WIDE_BYTES*8-1:0] wide_data [`EGR_NUM_PORTS-`EGR_NUM_NARROW],
    output logic [`EGR_WIDE_BYTES-1:0]   wide_keep [`EGR_NUM_PORTS-`EGR_NUM_NARROW],
    output logic [`EGR_NUM_PORTS-`EGR_NUM_NARROW-1:0] wide_last,
    input  logic [`EGR_NUM_PORTS-`EGR_NUM_NARROW-1:0] wide_ready,
    output egr_cnt_set_t                       egr_cnts [`EGR_NUM_PORTS],
    output logic [`EGR_NUM_PORTS-1:0]          egr_buf_full_drop
);

    logic [`EGR_NUM_PORTS-1:0] port_beat_valid;
    egr_beat_t                 port_beat;

    egr_port_demux u_demux (
        .egr_bus         (egr_bus),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_beat         (in_beat),
        .port_beat_valid (port_beat_valid),
        .port_beat       (port_beat)
    );

    ////////////////////
    // Narrow ports

    for (genvar i = 0; i < `EGR_NUM_NARROW; i++) begin : g_narrow
        egr_port #(
            .PORT_BYTES (`EGR_NARROW_BYTES)
        ) u_port (
            .egr_bus       (egr_bus),
            .rst_n         (rst_n),
            .enable        (egr_ports_enable[i]),
            .cnts_clear    (egr_cnts_clear[i]),
            .wr_valid      (port_beat_valid[i]),
            .wr_beat       (port_beat),
            .out_valid     (narrow_valid[i]),
            .out_data      (narrow_data[i]),
            .out_keep      (narrow_keep[i]),
            .out_last      (narrow_last[i]),
            .out_ready     (narrow_ready[i]),
            .cnts          (egr_cnts[i]),
            .buf_full_drop (egr_buf_full_drop[i])
        );
    end

    ////////////////////
    // Wide ports

    for (genvar j = 0; j < `EGR_NUM_PORTS - `EGR_NUM_NARROW; j++) begin : g_wide
        egr_port #(
            .PORT_BYTES (`EGR_WIDE_BYTES)
        ) u_port (
            .egr_bus       (egr_bus),
            .rst_n         (rst_n),
            .enable        (egr_ports_enable[`EGR_NUM_NARROW + j]),
            .cnts_clear    (egr_cnts_clear[`EGR_NUM_NARROW + j]),
            .wr_valid      (port_beat_valid[`EGR_NUM_NARROW + j]),
            .wr_beat       (port_beat),
            .out_valid     (wide_valid[j]),
            .out_data      (wide_data[j]),
            .out_keep      (wide_keep[j]),
            .out_last      (wide_last[j]),
            .out_ready     (wide_ready[j]),
            .cnts          (egr_cnts[`EGR_NUM_NARROW + j]),
            .buf_full_drop (egr_buf_full_drop[`EGR_NUM_NARROW + j])
        );
    end

endmodule
